// File: aluPkg.sv
`default_nettype none

package aluPkg;

	// --------------------
	// Widths
	// --------------------
	localparam int DataWidth    = 16;
	localparam int RegIdxWidth  = 4;
	localparam int ImmWidth     = 8;
	localparam int ApbAddrWidth = 12;
	localparam int ApbDataWidth = 32;

	// Opcode encoding, everything above ARSH is illegal
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		CMP  = 5'd2,
		AND  = 5'd3,
		OR   = 5'd4,
		XOR  = 5'd5,
		NOT  = 5'd6,
		LSH  = 5'd7,
		RSH  = 5'd8,
		ARSH = 5'd9
	} aluOp_e;

	// Flag register, n sits in the top bit
	typedef struct packed {
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
	} aluFlags_t;

	// Instruction word as written to CMD
	typedef struct packed {
		aluOp_e                 op;
		logic                   useImm;
		logic                   signedImm;
		logic [RegIdxWidth-1:0] rdest;
		logic [RegIdxWidth-1:0] rsrc;
		logic [ImmWidth-1:0]    imm;
	} instr_t;

	// --------------------
	// APB
	// --------------------
	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [ApbAddrWidth-1:0] paddr;
		logic [ApbDataWidth-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [ApbDataWidth-1:0] prdata;
		logic                    pready;
		logic                    pslverr;
	} apbRsp_t;

	// Host side of the register file, idx serves both read and write
	typedef struct packed {
		logic                   we;
		logic [RegIdxWidth-1:0] idx;
		logic [DataWidth-1:0]   wdata;
	} rfHostPort_t;

endpackage

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [aluPkg::DataWidth-1:0] rsrc,
	input  logic [aluPkg::DataWidth-1:0] rdest,
	input  aluPkg::aluOp_e               op,
	output logic [aluPkg::DataWidth-1:0] result,
	output aluPkg::aluFlags_t            flags
);
	import aluPkg::*;

	localparam int Msb = DataWidth - 1;

	// --------------------
	// Shared adder
	// --------------------
	logic                 subtract;
	logic [DataWidth-1:0] addOperand;
	logic [DataWidth-1:0] sum;
	logic                 carry;

	// SUB and CMP run as rdest + ~rsrc + 1
	assign subtract   = (op == SUB) || (op == CMP);
	assign addOperand = subtract ? ~rsrc : rsrc;

	assign {carry, sum} = {1'b0, rdest} + {1'b0, addOperand}
		+ {{DataWidth{1'b0}}, subtract};

	// --------------------
	// Flags
	// --------------------
	// Always driven, the execution unit picks which ones to keep
	always_comb begin
		flags.c = carry;
		flags.l = rdest < rsrc;
		// Overflow when both adder inputs agree in sign and the sum does not
		flags.f = (rdest[Msb] == addOperand[Msb]) && (sum[Msb] != rdest[Msb]);
		flags.z = rdest == rsrc;
		flags.n = $signed(rdest) < $signed(rsrc);
	end

	// --------------------
	// Result select
	// --------------------
	always_comb begin
		case (op)
			ADD, SUB, CMP: begin
				result = sum;
			end
			AND: begin
				result = rdest & rsrc;
			end
			OR: begin
				result = rdest | rsrc;
			end
			XOR: begin
				result = rdest ^ rsrc;
			end
			NOT: begin
				result = ~rsrc;
			end
			// Single-place shifts on the source operand
			LSH: begin
				result = {rsrc[Msb-1:0], 1'b0};
			end
			RSH: begin
				result = {1'b0, rsrc[Msb:1]};
			end
			ARSH: begin
				result = {rsrc[Msb], rsrc[Msb:1]};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic [aluPkg::RegIdxWidth-1:0] raddrA,
	input  logic [aluPkg::RegIdxWidth-1:0] raddrB,
	output logic [aluPkg::DataWidth-1:0]   rdataA,
	output logic [aluPkg::DataWidth-1:0]   rdataB,
	input  aluPkg::rfHostPort_t            host,
	output logic [aluPkg::DataWidth-1:0]   hostRdata,
	input  logic                           wbEn,
	input  logic [aluPkg::RegIdxWidth-1:0] wbIdx,
	input  logic [aluPkg::DataWidth-1:0]   wbData
);
	import aluPkg::*;

	localparam int NumRegs = 1 << RegIdxWidth;

	logic [DataWidth-1:0] regs [NumRegs];

	// Write-back wins over the host port
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbIdx] <= wbData;
		end else if (host.we) begin
			regs[host.idx] <= host.wdata;
		end
	end

	// --------------------
	// Read ports
	// --------------------
	assign rdataA    = regs[raddrA];
	assign rdataB    = regs[raddrB];
	assign hostRdata = regs[host.idx];

endmodule

`default_nettype wire

// File: execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           issue,
	input  aluPkg::instr_t                 instr,
	output logic [aluPkg::RegIdxWidth-1:0] raddrA,
	output logic [aluPkg::RegIdxWidth-1:0] raddrB,
	input  logic [aluPkg::DataWidth-1:0]   rdataA,
	input  logic [aluPkg::DataWidth-1:0]   rdataB,
	output logic [aluPkg::DataWidth-1:0]   aluRsrc,
	output logic [aluPkg::DataWidth-1:0]   aluRdest,
	output aluPkg::aluOp_e                 aluOp,
	input  logic [aluPkg::DataWidth-1:0]   aluResult,
	input  aluPkg::aluFlags_t              aluFlags,
	output logic                           wbEn,
	output logic [aluPkg::RegIdxWidth-1:0] wbIdx,
	output logic [aluPkg::DataWidth-1:0]   wbData,
	output aluPkg::aluFlags_t              flags,
	output logic                           illegal
);
	import aluPkg::*;

	logic                 legalOp;
	logic                 extBit;
	logic [DataWidth-1:0] immExt;

	// --------------------
	// Decode
	// --------------------
	assign legalOp = instr.op inside {ADD, SUB, CMP, AND, OR, XOR, NOT, LSH, RSH, ARSH};

	// Upper bits copy imm[7] only for a signed immediate
	assign extBit = instr.signedImm & instr.imm[ImmWidth-1];
	assign immExt = {{(DataWidth - ImmWidth){extBit}}, instr.imm};

	// Operand routing
	assign raddrA   = instr.rdest;
	assign raddrB   = instr.rsrc;
	assign aluRdest = rdataA;
	assign aluRsrc  = instr.useImm ? immExt : rdataB;
	assign aluOp    = instr.op;

	// --------------------
	// Write-back
	// --------------------
	// Lands at the edge that closes the issue cycle
	assign wbEn   = issue && legalOp && (instr.op != CMP);
	assign wbIdx  = instr.rdest;
	assign wbData = aluResult;

	// Flag register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (issue) begin
			case (instr.op)
				ADD, SUB: begin
					flags <= aluFlags;
				end
				CMP: begin
					flags.l <= aluFlags.l;
					flags.z <= aluFlags.z;
					flags.n <= aluFlags.n;
				end
				default: begin
					flags <= flags;
				end
			endcase
		end
	end

	// Sticky until the next legal command
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			illegal <= 1'b0;
		end else if (issue) begin
			illegal <= !legalOp;
		end
	end

endmodule

`default_nettype wire

// File: apbSlave.sv
`timescale 1ns/1ps
`default_nettype none

module apbSlave #(
	parameter int AddrWidth = 12
) (
	input  logic                         clk,
	input  logic                         arstN,
	input  aluPkg::apbReq_t              apbReq,
	output aluPkg::apbRsp_t              apbRsp,
	output aluPkg::rfHostPort_t          host,
	input  logic [aluPkg::DataWidth-1:0] hostRdata,
	output logic                         issue,
	output aluPkg::instr_t               instr,
	input  aluPkg::aluFlags_t            flags,
	input  logic                         illegal
);
	import aluPkg::*;

	// --------------------
	// Register map
	// --------------------
	localparam int RegSpan = (1 << RegIdxWidth) * 4;
	localparam logic [AddrWidth-1:0] RegLimit   = AddrWidth'(RegSpan);
	localparam logic [AddrWidth-1:0] CmdAddr    = AddrWidth'('h40);
	localparam logic [AddrWidth-1:0] FlagsAddr  = AddrWidth'('h44);
	localparam logic [AddrWidth-1:0] StatusAddr = AddrWidth'('h48);

	logic [AddrWidth-1:0] addr;
	logic                 access;
	logic                 isReg;
	logic                 isCmd;
	logic                 isFlags;
	logic                 isStatus;
	logic                 mapped;
	logic                 readOnly;
	logic                 cmdWrite;

	assign addr   = apbReq.paddr[AddrWidth-1:0];
	assign access = apbReq.psel && apbReq.penable;

	// General registers are word aligned below 0x40
	assign isReg    = (addr < RegLimit) && (addr[1:0] == 2'b00);
	assign isCmd    = addr == CmdAddr;
	assign isFlags  = addr == FlagsAddr;
	assign isStatus = addr == StatusAddr;
	assign mapped   = isReg || isCmd || isFlags || isStatus;
	assign readOnly = isFlags || isStatus;

	// --------------------
	// Register file host port
	// --------------------
	assign host.we    = access && apbReq.pwrite && isReg;
	assign host.idx   = addr[RegIdxWidth+1:2];
	assign host.wdata = apbReq.pwdata[DataWidth-1:0];

	// Response, no wait states
	always_comb begin
		apbRsp.prdata  = '0;
		apbRsp.pready  = 1'b1;
		apbRsp.pslverr = access && (!mapped || (apbReq.pwrite && readOnly));
		if (isReg) begin
			apbRsp.prdata[DataWidth-1:0] = hostRdata;
		end else if (isFlags) begin
			apbRsp.prdata[$bits(aluFlags_t)-1:0] = flags;
		end else if (isStatus) begin
			apbRsp.prdata[0] = illegal;
		end
	end

	// --------------------
	// Command issue
	// --------------------
	assign cmdWrite = access && apbReq.pwrite && isCmd;

	// One-cycle pulse after the completing edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			issue <= 1'b0;
		end else begin
			issue <= cmdWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (cmdWrite) begin
			instr <= instr_t'(apbReq.pwdata[$bits(instr_t)-1:0]);
		end
	end

endmodule

`default_nettype wire

// File: cr16Core.sv
`timescale 1ns/1ps
`default_nettype none

module cr16Core #(
	parameter int AddrWidth = 12
) (
	input  logic            clk,
	input  logic            arstN,
	input  aluPkg::apbReq_t apbReq,
	output aluPkg::apbRsp_t apbRsp
);
	import aluPkg::*;

	// --------------------
	// Interconnect
	// --------------------
	rfHostPort_t            host;
	logic [DataWidth-1:0]   hostRdata;
	logic                   issue;
	instr_t                 instr;
	aluFlags_t              flags;
	logic                   illegal;
	logic [RegIdxWidth-1:0] raddrA;
	logic [RegIdxWidth-1:0] raddrB;
	logic [DataWidth-1:0]   rdataA;
	logic [DataWidth-1:0]   rdataB;
	logic [DataWidth-1:0]   aluRsrc;
	logic [DataWidth-1:0]   aluRdest;
	aluOp_e                 aluOp;
	logic [DataWidth-1:0]   aluResult;
	aluFlags_t              aluFlags;
	logic                   wbEn;
	logic [RegIdxWidth-1:0] wbIdx;
	logic [DataWidth-1:0]   wbData;

	apbSlave #(
		.AddrWidth(AddrWidth)
	) u_apbSlave (
		.clk      (clk),
		.arstN    (arstN),
		.apbReq   (apbReq),
		.apbRsp   (apbRsp),
		.host     (host),
		.hostRdata(hostRdata),
		.issue    (issue),
		.instr    (instr),
		.flags    (flags),
		.illegal  (illegal)
	);

	execUnit u_execUnit (
		.clk      (clk),
		.arstN    (arstN),
		.issue    (issue),
		.instr    (instr),
		.raddrA   (raddrA),
		.raddrB   (raddrB),
		.rdataA   (rdataA),
		.rdataB   (rdataB),
		.aluRsrc  (aluRsrc),
		.aluRdest (aluRdest),
		.aluOp    (aluOp),
		.aluResult(aluResult),
		.aluFlags (aluFlags),
		.wbEn     (wbEn),
		.wbIdx    (wbIdx),
		.wbData   (wbData),
		.flags    (flags),
		.illegal  (illegal)
	);

	regFile u_regFile (
		.clk      (clk),
		.arstN    (arstN),
		.raddrA   (raddrA),
		.raddrB   (raddrB),
		.rdataA   (rdataA),
		.rdataB   (rdataB),
		.host     (host),
		.hostRdata(hostRdata),
		.wbEn     (wbEn),
		.wbIdx    (wbIdx),
		.wbData   (wbData)
	);

	alu u_alu (
		.rsrc  (aluRsrc),
		.rdest (aluRdest),
		.op    (aluOp),
		.result(aluResult),
		.flags (aluFlags)
	);

endmodule

`default_nettype wire

// File: cr16Core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cr16Core_checker (
	input logic              clk,
	input logic              arstN,
	input logic              issue,
	input aluPkg::instr_t    instr,
	input logic              wbEn,
	input aluPkg::aluFlags_t flags,
	input logic              illegal
);
	import aluPkg::*;

	logic isLegal;
	logic keepsFlags;

	assign isLegal    = instr.op inside {ADD, SUB, CMP, AND, OR, XOR, NOT, LSH, RSH, ARSH};
	assign keepsFlags = instr.op inside {AND, OR, XOR, NOT, LSH, RSH, ARSH};

	// Write-back belongs to the single cycle of an issue pulse
	wbInIssue: assert property (@(posedge clk) disable iff (!arstN)
		wbEn |-> issue && !$past(issue))
		else $error("wbEn high outside the first cycle of an issue pulse");

	// CMP neither writes back nor touches C and F
	cmpNoWrite: assert property (@(posedge clk) disable iff (!arstN)
		(issue && instr.op == CMP) |=> !$past(wbEn) && $stable(flags.c) && $stable(flags.f))
		else $error("CMP issued a write-back or changed C or F");

	// Logic and shift results leave the flag register alone
	flagsKept: assert property (@(posedge clk) disable iff (!arstN)
		(issue && keepsFlags) |=> $stable(flags))
		else $error("flags changed after a logic or shift issue");

	illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
		(issue && !isLegal) |=> !$past(wbEn) && illegal)
		else $error("illegal opcode wrote back or left the illegal bit clear");

endmodule

bind execUnit cr16Core_checker u_checker (
	.clk    (clk),
	.arstN  (arstN),
	.issue  (issue),
	.instr  (instr),
	.wbEn   (wbEn),
	.flags  (flags),
	.illegal(illegal)
);

`default_nettype wire

// File: tb_cr16Core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cr16Core;
	import aluPkg::*;

	localparam int ResetCycles  = 16;
	localparam int NumRandOps   = 60;
	localparam int NumCornerOps = 48;
	// Each APB transfer takes two 20 ns cycles
	localparam int NumTransfers = 80 + NumCornerOps * 6 + NumRandOps * 5;
	localparam int TimeoutNs    = ResetCycles * 20 + NumTransfers * 40 + 1000;
	localparam logic [ApbAddrWidth-1:0] CmdAddr    = 'h40;
	localparam logic [ApbAddrWidth-1:0] FlagsAddr  = 'h44;
	localparam logic [ApbAddrWidth-1:0] StatusAddr = 'h48;

	typedef struct packed {
		logic [DataWidth-1:0] result;
		aluFlags_t            flags;
	} aluRef_t;

	logic    clk;
	logic    arstN;
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	// Reference model state
	logic [DataWidth-1:0] shRegs [16];
	aluFlags_t            shFlags;
	logic                 shIllegal;

	logic [15:0] lfsrState = 16'd45890;
	logic [15:0] corners [4] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};
	string       nameQ [$];
	logic [31:0] gotQ [$];
	logic [31:0] expQ [$];
	event        sampled;
	int          checks = 0;
	int          errors = 0;

	cr16Core #(.AddrWidth(ApbAddrWidth)) u_cr16Core (
		.clk   (clk),
		.arstN (arstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	// --------------------
	// Stimulus helpers
	// --------------------
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic logic [ApbAddrWidth-1:0] regAddr(input logic [3:0] idx);
		return {{(ApbAddrWidth - 6){1'b0}}, idx, 2'b00};
	endfunction

	// Expected ALU behaviour
	function automatic aluRef_t refAlu(input logic [4:0] op, input logic [15:0] rd,
		input logic [15:0] rs);
		aluRef_t     r;
		logic [16:0] wide;
		r = '0;
		r.flags.l = rd < rs;
		r.flags.z = rd == rs;
		r.flags.n = $signed(rd) < $signed(rs);
		case (op)
			ADD: begin
				wide = {1'b0, rd} + {1'b0, rs};
				r.result  = wide[15:0];
				r.flags.c = wide[16];
				r.flags.f = (rd[15] == rs[15]) && (r.result[15] != rd[15]);
			end
			SUB, CMP: begin
				wide = {1'b0, rd} + {1'b0, ~rs} + 17'd1;
				r.result  = wide[15:0];
				r.flags.c = wide[16];
				r.flags.f = (rd[15] != rs[15]) && (r.result[15] != rd[15]);
			end
			AND:     r.result = rd & rs;
			OR:      r.result = rd | rs;
			XOR:     r.result = rd ^ rs;
			NOT:     r.result = ~rs;
			LSH:     r.result = rs << 1;
			RSH:     r.result = rs >> 1;
			ARSH:    r.result = 16'($signed(rs) >>> 1);
			default: r.result = '0;
		endcase
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic queueCheck(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		nameQ.push_back(name);
		gotQ.push_back(got);
		expQ.push_back(exp);
		-> sampled;
	endtask

	// Entered 2 ns after a rising edge, leaves at the same point
	task automatic apbXfer(input logic wr, input logic [ApbAddrWidth-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = wr;
		apbReq.paddr   = addr;
		apbReq.pwdata  = wdata;
		@(posedge clk);
		#2;
		apbReq.penable = 1'b1;
		#8;
		while (!apbRsp.pready) begin
			@(posedge clk);
			#10;
		end
		rdata = apbRsp.prdata;
		err   = apbRsp.pslverr;
		@(posedge clk);
		#2;
		apbReq.psel    = 1'b0;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = 1'b0;
	endtask

	task automatic writeReg(input logic [3:0] idx, input logic [15:0] value);
		logic [31:0] rdata;
		logic        err;
		apbXfer(1'b1, regAddr(idx), {16'h0, value}, rdata, err);
		queueCheck($sformatf("r%0d write pslverr", idx), {31'h0, err}, 32'h0);
		shRegs[idx] = value;
	endtask

	task automatic readExpect(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] rdata;
		logic        err;
		apbXfer(1'b0, addr, 32'h0, rdata, err);
		queueCheck(name, rdata, exp);
		queueCheck({name, " pslverr"}, {31'h0, err}, 32'h0);
	endtask

	task automatic errTransfer(input logic wr, input logic [ApbAddrWidth-1:0] addr,
		input string name);
		logic [31:0] rdata;
		logic        err;
		apbXfer(wr, addr, 32'hFFFF_FFFF, rdata, err);
		queueCheck({name, " pslverr"}, {31'h0, err}, 32'h1);
	endtask

	// Issue one command, update the model and read the state back
	task automatic runOp(input logic [4:0] op, input logic useImm, input logic signedImm,
		input logic [3:0] rd, input logic [3:0] rs, input logic [7:0] imm);
		logic [31:0] rdata;
		logic        err;
		logic [15:0] srcVal;
		aluRef_t     r;
		apbXfer(1'b1, CmdAddr, {9'h0, op, useImm, signedImm, rd, rs, imm}, rdata, err);
		queueCheck("CMD pslverr", {31'h0, err}, 32'h0);
		if (useImm) begin
			srcVal = signedImm ? 16'($signed(imm)) : {8'h00, imm};
		end else begin
			srcVal = shRegs[rs];
		end
		if (op > ARSH) begin
			shIllegal = 1'b1;
		end else begin
			r = refAlu(op, shRegs[rd], srcVal);
			shIllegal = 1'b0;
			if (op != CMP) begin
				shRegs[rd] = r.result;
			end
			if (op == ADD || op == SUB) begin
				shFlags = r.flags;
			end else if (op == CMP) begin
				shFlags.l = r.flags.l;
				shFlags.z = r.flags.z;
				shFlags.n = r.flags.n;
			end
		end
		readExpect(regAddr(rd), {16'h0, shRegs[rd]}, $sformatf("r%0d", rd));
		readExpect(FlagsAddr, {27'h0, shFlags}, "FLAGS");
		readExpect(StatusAddr, {31'h0, shIllegal}, "STATUS");
	endtask

	// --------------------
	// Processes
	// --------------------
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	initial begin
		forever begin
			@(sampled);
			while (gotQ.size() > 0) begin
				checkValue(nameQ.pop_front(), gotQ.pop_front(), expQ.pop_front());
			end
		end
	end

	initial begin
		#(TimeoutNs);
		$display("Timeout: the run did not finish within %0d ns", TimeoutNs);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [4:0] op;
		logic       useImm;
		logic       signedImm;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [7:0] imm;
		apbReq    = '0;
		arstN     = 1'b0;
		shFlags   = '0;
		shIllegal = 1'b0;
		for (int i = 0; i < 16; i++) begin
			shRegs[i] = '0;
		end
		repeat (ResetCycles) @(posedge clk);
		#2;
		arstN = 1'b1;
		@(posedge clk);
		#2;
		readExpect(FlagsAddr, 32'h0, "FLAGS");
		readExpect(StatusAddr, 32'h0, "STATUS");
		readExpect(regAddr(4'd9), 32'h0, "r9");

		// Host load and readback
		for (int i = 0; i < 16; i++) begin
			writeReg(4'(i), 16'(randBits(16)));
		end
		for (int i = 0; i < 16; i++) begin
			readExpect(regAddr(4'(i)), {16'h0, shRegs[i]}, $sformatf("r%0d", i));
		end
		errTransfer(1'b0, 'h04C, "read 0x4C");
		errTransfer(1'b0, 'h002, "read 0x02");
		errTransfer(1'b1, 'h800, "write 0x800");
		errTransfer(1'b1, FlagsAddr, "write FLAGS");
		errTransfer(1'b1, StatusAddr, "write STATUS");
		readExpect(FlagsAddr, 32'h0, "FLAGS");

		// ADD, SUB and CMP are opcodes 0 to 2
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					writeReg(4'd5, corners[i]);
					writeReg(4'd6, corners[j]);
					runOp(5'(k), 1'b0, 1'b0, 4'd5, 4'd6, 8'h00);
				end
			end
		end

		// Immediate extension
		writeReg(4'd3, 16'h1000);
		runOp(ADD, 1'b1, 1'b1, 4'd3, 4'd0, 8'h80);
		runOp(ADD, 1'b1, 1'b0, 4'd3, 4'd0, 8'h80);
		runOp(SUB, 1'b1, 1'b1, 4'd3, 4'd0, 8'hFF);
		runOp(XOR, 1'b1, 1'b0, 4'd3, 4'd0, 8'hFE);

		// Illegal opcodes, then a legal one clears STATUS
		writeReg(4'd7, 16'hA5A5);
		runOp(5'd10, 1'b0, 1'b0, 4'd7, 4'd2, 8'h00);
		runOp(5'd31, 1'b1, 1'b1, 4'd7, 4'd7, 8'hFF);
		runOp(OR, 1'b0, 1'b0, 4'd7, 4'd2, 8'h00);

		for (int i = 0; i < NumRandOps; i++) begin
			if (i % 8 == 0) begin
				rd = 4'(randBits(4));
				writeReg(rd, 16'(randBits(16)));
			end
			op        = 5'(randBits(4) % 10);
			useImm    = 1'(randBits(1));
			signedImm = 1'(randBits(1));
			rd        = 4'(randBits(4));
			rs        = 4'(randBits(4));
			imm       = 8'(randBits(8));
			runOp(op, useImm, signedImm, rd, rs, imm);
		end

		@(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cr16Core.f
aluPkg.sv
alu.sv
regFile.sv
execUnit.sv
apbSlave.sv
cr16Core.sv
cr16Core_checker.sv
tb_cr16Core.sv

// File: Bender.yml
package:
  name: cr16Core

sources:
  - aluPkg.sv
  - alu.sv
  - regFile.sv
  - execUnit.sv
  - apbSlave.sv
  - cr16Core.sv
  - target: simulation
    files:
      - cr16Core_checker.sv
      - tb_cr16Core.sv
